//--- rtl/periph_bus_pkg.sv
/*
 * Bus side definitions: address width, register address map
 * and the register index codes produced by the address decoder
 */
`default_nettype none

package periph_bus_pkg;

    localparam int ADDR_W = 8;
    localparam int REG_W = 5;

    // Register addresses as seen by the bus master
    localparam logic [ADDR_W-1:0] ADDR_PORTA  = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_PORTB  = 8'h01;
    localparam logic [ADDR_W-1:0] ADDR_PORTC  = 8'h02;
    localparam logic [ADDR_W-1:0] ADDR_PORTD  = 8'h03;
    localparam logic [ADDR_W-1:0] ADDR_DDRA   = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_DDRB   = 8'h05;
    localparam logic [ADDR_W-1:0] ADDR_DDRC   = 8'h06;
    localparam logic [ADDR_W-1:0] ADDR_SCCR2  = 8'h0F;
    localparam logic [ADDR_W-1:0] ADDR_SCSR   = 8'h10;
    localparam logic [ADDR_W-1:0] ADDR_SCDR   = 8'h11;
    localparam logic [ADDR_W-1:0] ADDR_TCR    = 8'h12;
    localparam logic [ADDR_W-1:0] ADDR_TSR    = 8'h13;
    localparam logic [ADDR_W-1:0] ADDR_ICR_HI = 8'h14;
    localparam logic [ADDR_W-1:0] ADDR_ICR_LO = 8'h15;
    localparam logic [ADDR_W-1:0] ADDR_OCR_HI = 8'h16;
    localparam logic [ADDR_W-1:0] ADDR_OCR_LO = 8'h17;
    localparam logic [ADDR_W-1:0] ADDR_ACR_HI = 8'h1A;
    localparam logic [ADDR_W-1:0] ADDR_ACR_LO = 8'h1B;

    // Register index codes, zero marks an unmapped address
    localparam logic [REG_W-1:0] REG_NONE   = 5'd0;
    localparam logic [REG_W-1:0] REG_PORTA  = 5'd1;
    localparam logic [REG_W-1:0] REG_PORTB  = 5'd2;
    localparam logic [REG_W-1:0] REG_PORTC  = 5'd3;
    localparam logic [REG_W-1:0] REG_PORTD  = 5'd4;
    localparam logic [REG_W-1:0] REG_DDRA   = 5'd5;
    localparam logic [REG_W-1:0] REG_DDRB   = 5'd6;
    localparam logic [REG_W-1:0] REG_DDRC   = 5'd7;
    localparam logic [REG_W-1:0] REG_SCCR2  = 5'd8;
    localparam logic [REG_W-1:0] REG_SCSR   = 5'd9;
    localparam logic [REG_W-1:0] REG_SCDR   = 5'd10;
    localparam logic [REG_W-1:0] REG_TCR    = 5'd11;
    localparam logic [REG_W-1:0] REG_TSR    = 5'd12;
    localparam logic [REG_W-1:0] REG_ICR_HI = 5'd13;
    localparam logic [REG_W-1:0] REG_ICR_LO = 5'd14;
    localparam logic [REG_W-1:0] REG_OCR_HI = 5'd15;
    localparam logic [REG_W-1:0] REG_OCR_LO = 5'd16;
    localparam logic [REG_W-1:0] REG_ACR_HI = 5'd17;
    localparam logic [REG_W-1:0] REG_ACR_LO = 5'd18;

endpackage

`default_nettype wire

//--- rtl/periph_reg_pkg.sv
/*
 * Register contents: data and counter widths, control and status
 * bit positions, and the timer word seen as a word or a byte pair
 */
`default_nettype none

package periph_reg_pkg;

    localparam int BYTE_W = 8;
    localparam int TIMER_W = 16;

    // Timer control register
    localparam int TCR_ICIE = 7;
    localparam int TCR_OCIE = 6;
    localparam int TCR_IEDG = 1;

    // Timer status register
    localparam int TSR_ICF = 7;
    localparam int TSR_OCF = 6;

    // Serial status and control 2
    localparam int SCSR_RDRF = 5;
    localparam int SCCR2_RIE = 5;

    // Counter, compare and capture values, bytes[0] is the high byte
    typedef union packed {
        logic [TIMER_W-1:0]         word;
        logic [0:1][BYTE_W-1:0]     bytes;
    } timer_word_u;

endpackage

`default_nettype wire

//--- rtl/periph_access_if.sv
/*
 * Decoded register access passed from the decode stage
 * to the execute and result stages
 */
`timescale 1ns/1ps
`default_nettype none

interface periph_access_if import periph_bus_pkg::*, periph_reg_pkg::*; ();

    logic              valid;
    logic              wr;
    logic [REG_W-1:0]  reg_idx;
    logic [BYTE_W-1:0] wdata;

    modport decode (output valid, wr, reg_idx, wdata);
    modport execute (input valid, wr, reg_idx, wdata);
    // Read path only needs to know what is being read
    modport result (input valid, wr, reg_idx);

endinterface

`default_nettype wire

//--- rtl/periph_state_if.sv
/*
 * Register contents published by the execute stage for the read mux
 */
`timescale 1ns/1ps
`default_nettype none

interface periph_state_if import periph_reg_pkg::*; ();

    logic [BYTE_W-1:0] porta_out;
    logic [BYTE_W-1:0] portb_out;
    logic [BYTE_W-1:0] portc_out;
    logic [BYTE_W-1:0] ddra;
    logic [BYTE_W-1:0] ddrb;
    logic [BYTE_W-1:0] ddrc;
    logic [BYTE_W-1:0] tcr;
    logic [BYTE_W-1:0] tsr;
    timer_word_u       icr;
    timer_word_u       ocr;
    timer_word_u       counter;
    logic [BYTE_W-1:0] acr_lo;
    logic [BYTE_W-1:0] sccr2;
    logic [BYTE_W-1:0] scsr;
    logic [BYTE_W-1:0] scdr;

    modport owner (
        output porta_out, portb_out, portc_out, ddra, ddrb, ddrc,
        output tcr, tsr, icr, ocr, counter, acr_lo, sccr2, scsr, scdr
    );
    modport view (
        input porta_out, portb_out, portc_out, ddra, ddrb, ddrc,
        input tcr, tsr, icr, ocr, counter, acr_lo, sccr2, scsr, scdr
    );

endinterface

`default_nettype wire

//--- rtl/access_decode.sv
/*
 * Bus access register stage with address to register index decode
 */
`timescale 1ns/1ps
`default_nettype none

module access_decode import periph_bus_pkg::*, periph_reg_pkg::*; (
    input  logic              clk30,
    input  logic              reset,
    input  logic              bus_valid,
    input  logic              bus_wr,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic [BYTE_W-1:0] bus_wdata,
    periph_access_if.decode   acc
);

    logic [REG_W-1:0] idx;

    always_comb begin
        case (bus_addr)
            ADDR_PORTA:  idx = REG_PORTA;
            ADDR_PORTB:  idx = REG_PORTB;
            ADDR_PORTC:  idx = REG_PORTC;
            ADDR_PORTD:  idx = REG_PORTD;
            ADDR_DDRA:   idx = REG_DDRA;
            ADDR_DDRB:   idx = REG_DDRB;
            ADDR_DDRC:   idx = REG_DDRC;
            ADDR_SCCR2:  idx = REG_SCCR2;
            ADDR_SCSR:   idx = REG_SCSR;
            ADDR_SCDR:   idx = REG_SCDR;
            ADDR_TCR:    idx = REG_TCR;
            ADDR_TSR:    idx = REG_TSR;
            ADDR_ICR_HI: idx = REG_ICR_HI;
            ADDR_ICR_LO: idx = REG_ICR_LO;
            ADDR_OCR_HI: idx = REG_OCR_HI;
            ADDR_OCR_LO: idx = REG_OCR_LO;
            ADDR_ACR_HI: idx = REG_ACR_HI;
            ADDR_ACR_LO: idx = REG_ACR_LO;
            default:     idx = REG_NONE;
        endcase
    end

    always_ff @(posedge clk30) begin
        if (reset) begin
            acc.valid   <= 1'b0;
            acc.wr      <= 1'b0;
            acc.reg_idx <= REG_NONE;
            acc.wdata   <= '0;
        end else begin
            acc.valid   <= bus_valid;
            acc.wr      <= bus_wr;
            acc.reg_idx <= idx;
            acc.wdata   <= bus_wdata;
        end
    end

endmodule

`default_nettype wire

//--- rtl/capture_timer.sv
/*
 * Prescaled 16-bit free-running counter with output compare,
 * input capture on a synchronised tcap pin, and the timer interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module capture_timer import periph_reg_pkg::*; #(
    parameter int PRESCALE = 30
) (
    input  logic              clk30,
    input  logic              reset,
    input  logic              wr_tcr,
    input  logic              wr_ocr_hi,
    input  logic              wr_ocr_lo,
    input  logic              rd_icr_lo,
    input  logic [BYTE_W-1:0] wdata,
    input  logic              tcap,
    output logic [BYTE_W-1:0] tcr,
    output logic [BYTE_W-1:0] tsr,
    output timer_word_u       counter,
    output timer_word_u       icr,
    output timer_word_u       ocr,
    output logic              timer_irq
);

    localparam int PS_W = $clog2(PRESCALE + 1);
    localparam logic [PS_W-1:0] PS_LAST = PS_W'(PRESCALE - 1);

    logic [PS_W-1:0] prescale_cnt;
    logic            icf;
    logic            ocf;
    logic            tcap_s1;
    logic            tcap_s2;
    logic            cap_edge;

    // IEDG set selects the rising edge
    assign cap_edge = tcr[TCR_IEDG] ? (tcap_s1 && !tcap_s2) : (!tcap_s1 && tcap_s2);

    always_comb begin
        tsr = '0;
        tsr[TSR_ICF] = icf;
        tsr[TSR_OCF] = ocf;
    end

    always_ff @(posedge clk30) begin
        if (reset) begin
            prescale_cnt <= '0;
            counter      <= '0;
        end else if (prescale_cnt == PS_LAST) begin
            prescale_cnt <= '0;
            counter.word <= counter.word + 1'b1;
        end else begin
            prescale_cnt <= prescale_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk30) begin
        if (reset) begin
            tcr <= '0;
            ocr <= '0;
        end else begin
            if (wr_tcr) tcr <= wdata;
            if (wr_ocr_hi) ocr.bytes[0] <= wdata;
            if (wr_ocr_lo) ocr.bytes[1] <= wdata;
        end
    end

    always_ff @(posedge clk30) begin
        if (reset) begin
            tcap_s1   <= 1'b0;
            tcap_s2   <= 1'b0;
            icf       <= 1'b0;
            ocf       <= 1'b0;
            icr       <= '0;
            timer_irq <= 1'b0;
        end else begin
            tcap_s1 <= tcap;
            tcap_s2 <= tcap_s1;

            // A match in the same cycle wins over the clearing write
            if (wr_ocr_lo) ocf <= 1'b0;
            if (counter.word == ocr.word) ocf <= 1'b1;

            if (rd_icr_lo) icf <= 1'b0;
            if (cap_edge) begin
                icf <= 1'b1;
                icr <= counter;
            end

            timer_irq <= (icf && tcr[TCR_ICIE]) || (ocf && tcr[TCR_OCIE]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/sci_receiver.sv
/*
 * Serial receive buffer: one data byte, RDRF flag, credit return
 */
`timescale 1ns/1ps
`default_nettype none

module sci_receiver import periph_reg_pkg::*; (
    input  logic              clk30,
    input  logic              reset,
    input  logic              rd_data,
    input  logic              rie,
    input  logic              rx_valid,
    input  logic [BYTE_W-1:0] rx_data,
    output logic [BYTE_W-1:0] scdr,
    output logic [BYTE_W-1:0] scsr,
    output logic              rx_credit,
    output logic              sci_irq
);

    logic rdrf;
    logic started;

    always_comb begin
        scsr = '0;
        scsr[SCSR_RDRF] = rdrf;
    end

    assign sci_irq = rdrf && rie;

    always_ff @(posedge clk30) begin
        if (reset) begin
            rdrf      <= 1'b0;
            started   <= 1'b0;
            rx_credit <= 1'b0;
            scdr      <= '0;
        end else begin
            started <= 1'b1;
            // First credit for the empty buffer, then one per drained byte
            rx_credit <= !started || (rd_data && rdrf);
            if (rd_data) rdrf <= 1'b0;
            if (rx_valid) begin
                rdrf <= 1'b1;
                scdr <= rx_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/periph_execute.sv
/*
 * Execute stage: port, DDR and SCCR2 registers, alternate counter latch,
 * register strobes, and the timer and serial receiver instances
 */
`timescale 1ns/1ps
`default_nettype none

module periph_execute import periph_bus_pkg::*, periph_reg_pkg::*; #(
    parameter int PRESCALE = 30
) (
    input  logic              clk30,
    input  logic              reset,
    periph_access_if.execute  acc,
    periph_state_if.owner     st,
    input  logic              tcap,
    input  logic              rx_valid,
    input  logic [BYTE_W-1:0] rx_data,
    output logic              rx_credit,
    output logic              timer_irq,
    output logic              sci_irq
);

    logic wr_en;
    logic rd_en;
    logic wr_tcr;
    logic wr_ocr_hi;
    logic wr_ocr_lo;
    logic rd_icr_lo;
    logic rd_acr_hi;
    logic rd_scdr;

    assign wr_en = acc.valid && acc.wr;
    assign rd_en = acc.valid && !acc.wr;

    assign wr_tcr    = wr_en && (acc.reg_idx == REG_TCR);
    assign wr_ocr_hi = wr_en && (acc.reg_idx == REG_OCR_HI);
    assign wr_ocr_lo = wr_en && (acc.reg_idx == REG_OCR_LO);
    assign rd_icr_lo = rd_en && (acc.reg_idx == REG_ICR_LO);
    assign rd_acr_hi = rd_en && (acc.reg_idx == REG_ACR_HI);
    assign rd_scdr   = rd_en && (acc.reg_idx == REG_SCDR);

    always_ff @(posedge clk30) begin
        if (reset) begin
            st.porta_out <= '0;
            st.portb_out <= '0;
            st.portc_out <= '0;
            st.ddra      <= '0;
            st.ddrb      <= '0;
            st.ddrc      <= '0;
            st.sccr2     <= '0;
            st.acr_lo    <= '0;
        end else begin
            if (wr_en) begin
                case (acc.reg_idx)
                    REG_PORTA: st.porta_out <= acc.wdata;
                    REG_PORTB: st.portb_out <= acc.wdata;
                    REG_PORTC: st.portc_out <= acc.wdata;
                    REG_DDRA:  st.ddra <= acc.wdata;
                    REG_DDRB:  st.ddrb <= acc.wdata;
                    REG_DDRC:  st.ddrc <= acc.wdata;
                    REG_SCCR2: st.sccr2 <= acc.wdata;
                    default: ;
                endcase
            end
            // Freeze the low byte so the ACR_LO read pairs with this high byte
            if (rd_acr_hi) begin
                st.acr_lo <= st.counter.bytes[1];
            end
        end
    end

    capture_timer #(
        .PRESCALE(PRESCALE)
    ) capture_timer_inst (
        .clk30     (clk30),
        .reset     (reset),
        .wr_tcr    (wr_tcr),
        .wr_ocr_hi (wr_ocr_hi),
        .wr_ocr_lo (wr_ocr_lo),
        .rd_icr_lo (rd_icr_lo),
        .wdata     (acc.wdata),
        .tcap      (tcap),
        .tcr       (st.tcr),
        .tsr       (st.tsr),
        .counter   (st.counter),
        .icr       (st.icr),
        .ocr       (st.ocr),
        .timer_irq (timer_irq)
    );

    sci_receiver sci_receiver_inst (
        .clk30     (clk30),
        .reset     (reset),
        .rd_data   (rd_scdr),
        .rie       (st.sccr2[SCCR2_RIE]),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .scdr      (st.scdr),
        .scsr      (st.scsr),
        .rx_credit (rx_credit),
        .sci_irq   (sci_irq)
    );

endmodule

`default_nettype wire

//--- rtl/read_result.sv
/*
 * Read data stage: port pin mixing, register select by index,
 * registered read data and read valid
 */
`timescale 1ns/1ps
`default_nettype none

module read_result import periph_bus_pkg::*, periph_reg_pkg::*; (
    input  logic              clk30,
    input  logic              reset,
    periph_access_if.result   acc,
    periph_state_if.view      st,
    input  logic [BYTE_W-1:0] porta_in,
    input  logic [BYTE_W-1:0] portb_in,
    input  logic [BYTE_W-1:0] portc_in,
    input  logic [BYTE_W-1:0] portd_in,
    output logic [BYTE_W-1:0] bus_rdata,
    output logic              bus_rvalid
);

    logic [BYTE_W-1:0] rdata_next;

    // Output latch where the DDR bit is set, pin otherwise
    function automatic logic [BYTE_W-1:0] port_mix(
        input logic [BYTE_W-1:0] out_q,
        input logic [BYTE_W-1:0] ddr,
        input logic [BYTE_W-1:0] pin
    );
        return (out_q & ddr) | (pin & ~ddr);
    endfunction

    always_comb begin
        case (acc.reg_idx)
            REG_PORTA:  rdata_next = port_mix(st.porta_out, st.ddra, porta_in);
            REG_PORTB:  rdata_next = port_mix(st.portb_out, st.ddrb, portb_in);
            REG_PORTC:  rdata_next = port_mix(st.portc_out, st.ddrc, portc_in);
            REG_PORTD:  rdata_next = portd_in;
            REG_DDRA:   rdata_next = st.ddra;
            REG_DDRB:   rdata_next = st.ddrb;
            REG_DDRC:   rdata_next = st.ddrc;
            REG_SCCR2:  rdata_next = st.sccr2;
            REG_SCSR:   rdata_next = st.scsr;
            REG_SCDR:   rdata_next = st.scdr;
            REG_TCR:    rdata_next = st.tcr;
            REG_TSR:    rdata_next = st.tsr;
            REG_ICR_HI: rdata_next = st.icr.bytes[0];
            REG_ICR_LO: rdata_next = st.icr.bytes[1];
            REG_OCR_HI: rdata_next = st.ocr.bytes[0];
            REG_OCR_LO: rdata_next = st.ocr.bytes[1];
            REG_ACR_HI: rdata_next = st.counter.bytes[0];
            REG_ACR_LO: rdata_next = st.acr_lo;
            default:    rdata_next = '0;
        endcase
    end

    always_ff @(posedge clk30) begin
        if (reset) begin
            bus_rdata  <= '0;
            bus_rvalid <= 1'b0;
        end else begin
            bus_rvalid <= acc.valid && !acc.wr;
            if (acc.valid && !acc.wr) begin
                bus_rdata <= rdata_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uc_periph_top.sv
/*
 * Peripheral block top: decode, execute and read result stages
 * joined by the access and state interfaces
 */
`timescale 1ns/1ps
`default_nettype none

module uc_periph_top import periph_bus_pkg::*, periph_reg_pkg::*; #(
    parameter int PRESCALE = 30
) (
    input  logic              clk30,
    input  logic              reset,
    input  logic              bus_valid,
    input  logic              bus_wr,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic [BYTE_W-1:0] bus_wdata,
    output logic [BYTE_W-1:0] bus_rdata,
    output logic              bus_rvalid,
    input  logic [BYTE_W-1:0] porta_in,
    input  logic [BYTE_W-1:0] portb_in,
    input  logic [BYTE_W-1:0] portc_in,
    input  logic [BYTE_W-1:0] portd_in,
    output logic [BYTE_W-1:0] porta_out,
    output logic [BYTE_W-1:0] portb_out,
    output logic [BYTE_W-1:0] portc_out,
    output logic [BYTE_W-1:0] ddra,
    output logic [BYTE_W-1:0] ddrb,
    output logic [BYTE_W-1:0] ddrc,
    input  logic              tcap,
    output logic              timer_irq,
    input  logic              rx_valid,
    input  logic [BYTE_W-1:0] rx_data,
    output logic              rx_credit,
    output logic              sci_irq
);

    periph_access_if acc ();
    periph_state_if  st ();

    access_decode access_decode_inst (
        .clk30     (clk30),
        .reset     (reset),
        .bus_valid (bus_valid),
        .bus_wr    (bus_wr),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .acc       (acc.decode)
    );

    periph_execute #(
        .PRESCALE(PRESCALE)
    ) periph_execute_inst (
        .clk30     (clk30),
        .reset     (reset),
        .acc       (acc.execute),
        .st        (st.owner),
        .tcap      (tcap),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_credit (rx_credit),
        .timer_irq (timer_irq),
        .sci_irq   (sci_irq)
    );

    read_result read_result_inst (
        .clk30      (clk30),
        .reset      (reset),
        .acc        (acc.result),
        .st         (st.view),
        .porta_in   (porta_in),
        .portb_in   (portb_in),
        .portc_in   (portc_in),
        .portd_in   (portd_in),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid)
    );

    assign porta_out = st.porta_out;
    assign portb_out = st.portb_out;
    assign portc_out = st.portc_out;
    assign ddra      = st.ddra;
    assign ddrb      = st.ddrb;
    assign ddrc      = st.ddrc;

endmodule

`default_nettype wire

//--- tb/tb_top.sv
/*
 * Testbench for the peripheral block: clock and reset, LFSR stimulus,
 * reference model of ports, serial receive and timer, checks and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top import periph_bus_pkg::*, periph_reg_pkg::*; ();

    localparam int PRESCALE = 5;
    localparam int N_PORT = 40;
    localparam int N_RX = 24;
    localparam int N_CNT = 20;
    localparam int N_OC = 4;
    localparam int N_IC = 6;
    // Rough cycle cost per iteration of each test, doubled for margin
    localparam int LIMIT_CYCLES = 2 * (N_PORT * 40 + N_RX * 80 + N_CNT * 10
        + N_OC * (PRESCALE * 16 + 40) + N_IC * 60 + 100);

    logic       clk30;
    logic       reset;
    logic       bus_valid;
    logic       bus_wr;
    logic [7:0] bus_addr;
    logic [7:0] bus_wdata;
    logic [7:0] bus_rdata;
    logic       bus_rvalid;
    logic [7:0] pin [4];
    logic [7:0] out_w [3];
    logic [7:0] ddr_w [3];
    logic       tcap;
    logic       timer_irq;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_credit;
    logic       sci_irq;

    // Reference model
    logic [15:0] lfsr;
    int          credits = 0;
    int          cycles = 0;
    logic [7:0]  port_m [3];
    logic [7:0]  ddr_m [3];
    logic [7:0]  sccr2_m;
    logic [7:0]  tcr_m;
    logic [7:0]  sent_q [$];

    uc_periph_top #(
        .PRESCALE(PRESCALE)
    ) uc_periph_top_inst (
        .clk30      (clk30),
        .reset      (reset),
        .bus_valid  (bus_valid),
        .bus_wr     (bus_wr),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .porta_in   (pin[0]),
        .portb_in   (pin[1]),
        .portc_in   (pin[2]),
        .portd_in   (pin[3]),
        .porta_out  (out_w[0]),
        .portb_out  (out_w[1]),
        .portc_out  (out_w[2]),
        .ddra       (ddr_w[0]),
        .ddrb       (ddr_w[1]),
        .ddrc       (ddr_w[2]),
        .tcap       (tcap),
        .timer_irq  (timer_irq),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_credit  (rx_credit),
        .sci_irq    (sci_irq)
    );

    initial clk30 = 1'b0;
    always #5 clk30 = ~clk30;

    // Clock edges since reset release as the timer's time base
    always @(posedge clk30) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch");
        end
    endtask

    // One buffer slot, so at most one credit is ever held
    always @(negedge clk30) begin
        if (!reset && rx_credit) begin
            credits = credits + 1;
            check("rx_credits_held", credits, (credits > 1) ? 1 : credits);
        end
    end

    // Galois LFSR over x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk30);
            #1;
        end
    endtask

    task automatic drive_access(input logic wr, input logic [7:0] addr, input logic [7:0] data);
        bus_valid = 1'b1;
        bus_wr = wr;
        bus_addr = addr;
        bus_wdata = data;
        @(posedge clk30);
        #1;
        bus_valid = 1'b0;
        bus_wr = 1'b0;
    endtask

    // Returns once the execute stage has applied the write
    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        drive_access(1'b1, addr, data);
        @(posedge clk30);
        #1;
        check("bus_rvalid_after_write", 32'(bus_rvalid), 0);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
        drive_access(1'b0, addr, 8'h00);
        while (!bus_rvalid) begin
            @(posedge clk30);
            #1;
        end
        data = bus_rdata;
    endtask

    task automatic read_counter(output logic [15:0] value);
        logic [7:0] hi;
        logic [7:0] lo;
        read_reg(ADDR_ACR_HI, hi);
        read_reg(ADDR_ACR_LO, lo);
        value = {hi, lo};
    endtask

    task automatic wait_tsr_flag(input int bit_pos, output logic [7:0] tsr);
        tsr = 8'h00;
        while (!tsr[bit_pos]) begin
            read_reg(ADDR_TSR, tsr);
        end
    endtask

    task automatic exercise_ports();
        int         idx;
        logic [7:0] value;
        logic [7:0] expect_v;
        for (int i = 0; i < N_PORT; i++) begin
            idx = int'(rand_bits(2) % 3);
            port_m[idx] = 8'(rand_bits(8));
            ddr_m[idx] = 8'(rand_bits(8));
            write_reg(8'(ADDR_PORTA + idx), port_m[idx]);
            write_reg(8'(ADDR_DDRA + idx), ddr_m[idx]);
            for (int k = 0; k < 3; k++) begin
                check($sformatf("port_out[%0d]", k), 32'(out_w[k]), 32'(port_m[k]));
                check($sformatf("ddr[%0d]", k), 32'(ddr_w[k]), 32'(ddr_m[k]));
            end
            for (int k = 0; k < 4; k++) begin
                pin[k] = 8'(rand_bits(8));
            end
            read_reg(8'(ADDR_PORTA + idx), value);
            expect_v = (port_m[idx] & ddr_m[idx]) | (pin[idx] & ~ddr_m[idx]);
            check($sformatf("port_rdata[%0d]", idx), 32'(value), 32'(expect_v));
            read_reg(8'(ADDR_DDRA + idx), value);
            check($sformatf("ddr_rdata[%0d]", idx), 32'(value), 32'(ddr_m[idx]));
            read_reg(ADDR_PORTD, value);
            check("portd_rdata", 32'(value), 32'(pin[3]));
            read_reg(8'(8'h1C + rand_bits(7)), value);
            check("unmapped_rdata", 32'(value), 0);
            write_reg(8'(8'h1C + rand_bits(7)), 8'hFF);
            check("port_out_after_unmapped", 32'(out_w[idx]), 32'(port_m[idx]));
        end
    endtask

    task automatic send_bytes(input int count);
        for (int i = 0; i < count; i++) begin
            while (credits == 0 || rand_bits(1) == 0) begin
                @(posedge clk30);
                #1;
            end
            rx_data = 8'(rand_bits(8));
            rx_valid = 1'b1;
            credits = credits - 1;
            sent_q.push_back(rx_data);
            @(posedge clk30);
            #1;
            rx_valid = 1'b0;
        end
    endtask

    task automatic receive_bytes(input int count);
        logic [7:0] value;
        logic [7:0] expect_v;
        for (int i = 0; i < count; i++) begin
            value = 8'h00;
            while (!value[SCSR_RDRF]) begin
                read_reg(ADDR_SCSR, value);
            end
            sccr2_m = 8'(rand_bits(8));
            write_reg(ADDR_SCCR2, sccr2_m);
            read_reg(ADDR_SCCR2, value);
            check("sccr2_rdata", 32'(value), 32'(sccr2_m));
            check("sci_irq", 32'(sci_irq), 32'(sccr2_m[SCCR2_RIE]));
            read_reg(ADDR_SCDR, value);
            expect_v = sent_q.pop_front();
            check("scdr_rdata", 32'(value), 32'(expect_v));
            check("sci_irq_after_read", 32'(sci_irq), 0);
        end
    endtask

    task automatic sample_counter();
        logic [15:0] value;
        logic [15:0] prev;
        logic [31:0] expect_v;
        prev = 16'h0000;
        for (int i = 0; i < N_CNT; i++) begin
            expect_v = 32'(cycles / PRESCALE);
            read_counter(value);
            check("acr_value", 32'(value), (32'(value) == expect_v + 1) ? 32'(value) : expect_v);
            check("acr_monotonic", 32'(value), (value >= prev) ? 32'(value) : 32'(prev));
            prev = value;
            wait_cycles(int'(rand_bits(3)));
        end
    endtask

    task automatic hit_output_compare();
        logic [15:0] now;
        logic [15:0] target;
        logic [7:0]  value;
        tcr_m = 8'h00;
        tcr_m[TCR_OCIE] = 1'b1;
        write_reg(ADDR_TCR, tcr_m);
        for (int i = 0; i < N_OC; i++) begin
            read_counter(now);
            target = 16'(now + 5 + rand_bits(3));
            write_reg(ADDR_OCR_HI, target[15:8]);
            write_reg(ADDR_OCR_LO, target[7:0]);
            read_reg(ADDR_TSR, value);
            check("tsr_ocf_before_match", 32'(value[TSR_OCF]), 0);
            wait_tsr_flag(TSR_OCF, value);
            check("timer_irq_ocf", 32'(timer_irq), 1);
            read_counter(now);
            check("counter_at_ocf", 32'(now), (now >= target) ? 32'(now) : 32'(target));
            // Rewriting the low byte clears OCF and the irq drops a cycle later
            write_reg(ADDR_OCR_LO, target[7:0]);
            wait_cycles(1);
            check("timer_irq_ocf_cleared", 32'(timer_irq), 0);
            read_reg(ADDR_TSR, value);
            check("tsr_ocf_cleared", 32'(value[TSR_OCF]), 0);
        end
    endtask

    task automatic capture_input_edges();
        logic [15:0] before_v;
        logic [15:0] after_v;
        logic [15:0] icr_v;
        logic [7:0]  hi;
        logic [7:0]  lo;
        logic [7:0]  value;
        logic        rising;
        for (int i = 0; i < N_IC; i++) begin
            rising = 1'(rand_bits(1));
            tcr_m = 8'h00;
            tcr_m[TCR_ICIE] = 1'(rand_bits(1));
            tcr_m[TCR_IEDG] = rising;
            // Park the pin at its idle level and drop any stale capture
            tcap = !rising;
            wait_cycles(4);
            read_reg(ADDR_ICR_LO, value);
            write_reg(ADDR_TCR, tcr_m);
            read_reg(ADDR_TSR, value);
            check("tsr_icf_idle", 32'(value[TSR_ICF]), 0);
            read_counter(before_v);
            tcap = rising;
            wait_tsr_flag(TSR_ICF, value);
            check("timer_irq_icf", 32'(timer_irq), 32'(tcr_m[TCR_ICIE]));
            read_counter(after_v);
            read_reg(ADDR_ICR_HI, hi);
            read_reg(ADDR_ICR_LO, lo);
            icr_v = {hi, lo};
            check("icr_vs_before", 32'(icr_v), (icr_v >= before_v) ? 32'(icr_v) : 32'(before_v));
            check("icr_vs_after", 32'(icr_v), (icr_v <= after_v) ? 32'(icr_v) : 32'(after_v));
            read_reg(ADDR_TSR, value);
            check("tsr_icf_cleared", 32'(value[TSR_ICF]), 0);
            check("timer_irq_icf_cleared", 32'(timer_irq), 0);
            // Opposite edge must not capture
            tcap = !rising;
            wait_cycles(4);
            read_reg(ADDR_TSR, value);
            check("tsr_icf_wrong_edge", 32'(value[TSR_ICF]), 0);
        end
    endtask

    initial begin
        lfsr = 16'd30842;
        reset = 1'b1;
        bus_valid = 1'b0;
        bus_wr = 1'b0;
        bus_addr = 8'h00;
        bus_wdata = 8'h00;
        pin = '{default: 8'h00};
        tcap = 1'b0;
        rx_valid = 1'b0;
        rx_data = 8'h00;
        port_m = '{default: 8'h00};
        ddr_m = '{default: 8'h00};
        sccr2_m = 8'h00;
        tcr_m = 8'h00;
        repeat (3) @(posedge clk30);
        #1;
        reset = 1'b0;
        check("bus_rvalid_reset", 32'(bus_rvalid), 0);
        check("rx_credit_reset", 32'(rx_credit), 0);
        check("timer_irq_reset", 32'(timer_irq), 0);
        check("sci_irq_reset", 32'(sci_irq), 0);

        exercise_ports();
        fork
            send_bytes(N_RX);
            receive_bytes(N_RX);
        join
        check("rx_bytes_left", sent_q.size(), 0);
        sample_counter();
        hit_output_compare();
        capture_input_edges();

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * 10);
        $display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/periph_bus_pkg.sv
rtl/periph_reg_pkg.sv
rtl/periph_access_if.sv
rtl/periph_state_if.sv
rtl/access_decode.sv
rtl/capture_timer.sv
rtl/sci_receiver.sv
rtl/periph_execute.sv
rtl/read_result.sv
rtl/uc_periph_top.sv
tb/tb_top.sv

//--- Makefile
TOP := tb_top

sim:
	verilator --binary -f tb.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

.PHONY: sim clean
